/* build.f */
hdl/cachePkg.sv
hdl/tagArray.sv
hdl/dataArray.sv
hdl/lruState.sv
hdl/busController.sv
hdl/cacheTop.sv
verification/cacheTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cacheTb
SEED_LOG ?= sim.log
OBJ_DIR ?= obj_dir
FILELIST ?= build.f
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR, TOP, SEED_LOG, OBJ_DIR, FILELIST, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(SEED_LOG)
	@grep -q "^Test OK$$" $(SEED_LOG) || (echo "simulation failed, see $(SEED_LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

/* verification/cacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheTb;

	localparam logic [31:0] SEED = 32'h1a36475e;
	localparam logic [31:0] CCR_WORD = 32'hFFFFFE90;
	localparam int RANDOM_TX = 300;
	localparam int LRU_TX = 40;
	localparam int TOTAL_TX = RANDOM_TX + 2 * LRU_TX + 3;
	localparam int TIMEOUT_CYCLES = TOTAL_TX * 200 + 1000;

	typedef struct packed {
		logic        wr;
		logic        lock;
		logic [3:0]  be;
		logic [31:0] addr;
		logic [31:0] data;
	} sysXfer_t;

	logic        CLK = 1'b0;
	logic        RST_N;
	logic [31:0] cpuAddr;
	logic [31:0] cpuWdata;
	logic        cpuWrite;
	logic [3:0]  cpuByteEn;
	logic        cpuReq;
	logic [31:0] cpuRdata;
	logic        cpuBusy;
	logic [31:0] sysAddr;
	logic [31:0] sysRdata;
	logic [31:0] sysWdata;
	logic [3:0]  sysByteEn;
	logic        sysWrite;
	logic        sysReq;
	logic        sysWait;
	logic        sysLock;

	logic [31:0] stimSeed;
	logic [31:0] respSeed;
	logic        newXfer;
	logic        purgeBusy;
	logic [7:0]  ccrM;
	logic [31:0] refMem [logic [29:0]];
	logic [31:0] sysMem [logic [29:0]];
	sysXfer_t    expQ [$];
	logic        mValid [64][4];
	logic [18:0] mTag [64][4];
	int          mRank [64][4];
	int          errors = 0;
	int          checks = 0;
	int          txCount = 0;

	cacheTop #(.SET_BITS(6)) cacheTop_i (
		.CLK(CLK), .RST_N(RST_N),
		.cpuAddr(cpuAddr), .cpuWdata(cpuWdata), .cpuWrite(cpuWrite),
		.cpuByteEn(cpuByteEn), .cpuReq(cpuReq),
		.cpuRdata(cpuRdata), .cpuBusy(cpuBusy),
		.sysAddr(sysAddr), .sysRdata(sysRdata), .sysWdata(sysWdata),
		.sysByteEn(sysByteEn), .sysWrite(sysWrite), .sysReq(sysReq),
		.sysWait(sysWait), .sysLock(sysLock)
	);

	always #2 CLK = ~CLK;

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
	endfunction

	task automatic takeBits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = 32'h0;
		for (int i = 0; i < n; i++) begin
			st = lfsrNext(st);
			v = {v[30:0], st[0]};
		end
	endtask

	// memory words that were never written hold a value made from their address.
	function automatic logic [31:0] initWord(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h5A3C96E1 ^ (a << 7);
	endfunction

	function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] nw,
	                                           input logic [3:0] be);
		logic [31:0] res;

		res = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				res[8*b +: 8] = nw[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [31:0] refRead(input logic [31:0] a);
		return refMem.exists(a[31:2]) ? refMem[a[31:2]] : initWord({a[31:2], 2'b00});
	endfunction

	function automatic logic [31:0] sysRead(input logic [31:0] a);
		return sysMem.exists(a[31:2]) ? sysMem[a[31:2]] : initWord({a[31:2], 2'b00});
	endfunction

	function automatic sysXfer_t makeXfer(input logic wr, input logic lock, input logic [3:0] be,
	                                      input logic [31:0] addr, input logic [31:0] data);
		sysXfer_t x;

		x.wr = wr;
		x.lock = lock;
		x.be = be;
		x.addr = addr;
		x.data = data;
		return x;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	// the model keeps a true LRU order, rank 0 being the most recent way.
	task automatic purgeModel();
		for (int s = 0; s < 64; s++) begin
			for (int w = 0; w < 4; w++) begin
				mValid[s][w] = 1'b0;
				mRank[s][w] = w;
			end
		end
	endtask

	task automatic touchWay(input logic [5:0] s, input int w);
		int r;

		r = mRank[s][w];
		for (int v = 0; v < 4; v++) begin
			if (mRank[s][v] < r) begin
				mRank[s][v]++;
			end
		end
		mRank[s][w] = 0;
	endtask

	function automatic int lookupWay(input logic [31:0] a);
		int res;

		res = -1;
		for (int w = 0; w < 4; w++) begin
			if (mValid[a[9:4]][w] && mTag[a[9:4]][w] == a[28:10]) begin
				res = w;
			end
		end
		return res;
	endfunction

	function automatic int pickVictim(input logic [5:0] s);
		int res;

		if (ccrM[3]) begin
			res = (mRank[s][2] > mRank[s][3]) ? 2 : 3;
		end else begin
			res = 0;
			for (int w = 1; w < 4; w++) begin
				if (mRank[s][w] > mRank[s][res]) begin
					res = w;
				end
			end
		end
		return res;
	endfunction

	task automatic cpuAccess(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
	                         input logic [3:0] be, output logic [31:0] rdata, output int cycles);
		logic done;

		cpuReq = 1'b1;
		cpuWrite = wr;
		cpuAddr = addr;
		cpuWdata = wdata;
		cpuByteEn = be;
		done = 1'b0;
		cycles = 0;
		while (!done) begin
			@(negedge CLK);
			done = !cpuBusy;
			rdata = cpuRdata;
			cycles++;
			@(posedge CLK);
			#0.5;
		end
		cpuReq = 1'b0;
	endtask

	// the expected system transfers are queued before the request is issued.
	task automatic runAccess(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
	                         input logic [3:0] be);
		logic [31:0] expRd;
		logic [31:0] got;
		logic [5:0]  setIdx;
		logic [1:0]  wo;
		logic        cached;
		logic        single;
		int          way;
		int          vic;
		int          cycles;

		setIdx = addr[9:4];
		cached = (addr[31:29] == 3'b000) && ccrM[0];
		expRd = 32'h0;
		way = lookupWay(addr);
		// with the system bus idle, an access that needs no system read ends in its first cycle.
		single = (expQ.size() == 0) && !purgeBusy;
		purgeBusy = 1'b0;
		if (addr[31:2] == CCR_WORD[31:2] && be[1]) begin
			if (wr) begin
				ccrM = wdata[15:8] & 8'h19;
				if (ccrM[4]) begin
					purgeModel();
					ccrM[4] = 1'b0;
					purgeBusy = 1'b1;
				end
			end else begin
				expRd = {4{ccrM & 8'h09}};
			end
		end else if (addr[31:29] != 3'b000 && addr[31:29] != 3'b001 && addr[31:29] != 3'b111) begin
			expRd = 32'h0;
		end else if (wr) begin
			expQ.push_back(makeXfer(1'b1, 1'b0, be, addr, wdata));
			refMem[addr[31:2]] = mergeBytes(refRead(addr), wdata, be);
			if (cached && way >= 0) begin
				touchWay(setIdx, way);
			end
		end else begin
			expRd = refRead(addr);
			if (cached && way >= 0) begin
				touchWay(setIdx, way);
			end else if (cached) begin
				single = 1'b0;
				vic = pickVictim(setIdx);
				wo = addr[3:2];
				for (int i = 0; i < 4; i++) begin
					wo = wo + 2'd1;
					expQ.push_back(makeXfer(1'b0, i < 3, 4'hF, {addr[31:4], wo, 2'b00}, 32'h0));
				end
				mValid[setIdx][vic] = 1'b1;
				mTag[setIdx][vic] = addr[28:10];
				touchWay(setIdx, vic);
			end else begin
				single = 1'b0;
				expQ.push_back(makeXfer(1'b0, 1'b0, be, addr, 32'h0));
			end
		end
		cpuAccess(wr, addr, wdata, be, got, cycles);
		txCount++;
		if (!wr) begin
			checkValue("cpuRdata", got, expRd);
		end
		if (single) begin
			checkValue("cpuBusy cycles", cycles, 32'd1);
		end
	endtask

	task automatic randomAccess();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] wd;
		logic [3:0]  kind;
		logic [3:0]  be;
		logic [7:0]  ccrByte;
		logic        wr;

		takeBits(stimSeed, 4, r);
		kind = r[3:0];
		takeBits(stimSeed, 1, r);
		wr = r[0];
		takeBits(stimSeed, 7, r);
		a = {19'h0, r[6:4], 4'h0, r[3:2], r[1:0], 2'b00};
		takeBits(stimSeed, 32, wd);
		takeBits(stimSeed, 4, r);
		be = (r[3:0] == 4'h0) ? 4'hF : r[3:0];
		if (kind == 4'd0) begin
			takeBits(stimSeed, 8, r);
			ccrByte = r[7:0];
			// turning the cache on again also purges it, so no stale line survives.
			if (ccrByte[0] && !ccrM[0]) begin
				ccrByte[4] = 1'b1;
			end
			if (wr) begin
				runAccess(1'b1, CCR_WORD, {wd[31:16], ccrByte, wd[7:0]}, 4'b0010);
			end else begin
				runAccess(1'b0, CCR_WORD, 32'h0, 4'hF);
			end
		end else begin
			case (kind)
				4'd1:        a = a | 32'h6000_0000;
				4'd2, 4'd3:  a = a | 32'hE000_0000;
				4'd4, 4'd5:  a = a | 32'h2000_0000;
				default:     a = a;
			endcase
			if (!wr) begin
				be = 4'hF;
			end
			runAccess(wr, a, wd, be);
		end
	endtask

	// five tags share set 37, so replacement order shows up in the line fills.
	task automatic lruPhase(input logic tw);
		logic [31:0] r;
		logic [31:0] a;
		logic [2:0]  pick;

		runAccess(1'b1, CCR_WORD, {16'h0, 3'b000, 1'b1, tw, 2'b00, 1'b1, 8'h00}, 4'b0010);
		for (int n = 0; n < LRU_TX; n++) begin
			takeBits(stimSeed, 3, r);
			pick = (r[2:0] > 3'd4) ? r[2:0] - 3'd4 : r[2:0];
			takeBits(stimSeed, 2, r);
			a = {3'b000, 16'h0000, pick, 6'd37, r[1:0], 2'b00};
			runAccess(1'b0, a, 32'h0, 4'hF);
		end
	endtask

	task automatic respondLoop();
		logic [31:0] r;
		logic [1:0]  waitLeft;

		waitLeft = 2'd0;
		forever begin
			@(posedge CLK);
			#0.5;
			if (sysReq && newXfer) begin
				takeBits(respSeed, 2, r);
				waitLeft = r[1:0];
				newXfer = 1'b0;
			end
			sysWait = sysReq && (waitLeft != 2'd0);
			if (sysWait) begin
				waitLeft = waitLeft - 2'd1;
			end
			if (sysReq) begin
				sysRdata = sysRead(sysAddr);
			end
		end
	endtask

	// a transfer is taken at the next rising edge when it is requested and not held off.
	task automatic monitorLoop();
		sysXfer_t x;

		forever begin
			@(negedge CLK);
			if (RST_N && sysReq && !sysWait) begin
				if (sysWrite) begin
					sysMem[sysAddr[31:2]] = mergeBytes(sysRead(sysAddr), sysWdata, sysByteEn);
				end
				assert (expQ.size() != 0) else begin
					$display("Unexpected system transfer to address %h.", sysAddr);
					errors++;
				end
				if (expQ.size() != 0) begin
					x = expQ.pop_front();
					checkValue("sysAddr", sysAddr, x.addr);
					checkValue("sysWrite", {31'h0, sysWrite}, {31'h0, x.wr});
					checkValue("sysByteEn", {28'h0, sysByteEn}, {28'h0, x.be});
					checkValue("sysLock", {31'h0, sysLock}, {31'h0, x.lock});
					if (x.wr) begin
						checkValue("sysWdata", sysWdata, x.data);
					end
				end
				newXfer = 1'b1;
			end
		end
	endtask

	task automatic printCounts();
		$display("Transactions: %0d, checks: %0d, errors: %0d", txCount, checks, errors);
	endtask

	task automatic watchdog();
		#(TIMEOUT_CYCLES * 4);
		$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
		printCounts();
		$display("Test FAILED");
		$finish;
	endtask

	initial begin
		RST_N = 1'b0;
		cpuAddr = 32'h0;
		cpuWdata = 32'h0;
		cpuWrite = 1'b0;
		cpuByteEn = 4'h0;
		cpuReq = 1'b0;
		sysRdata = 32'h0;
		sysWait = 1'b0;
		stimSeed = SEED;
		respSeed = SEED;
		newXfer = 1'b1;
		purgeBusy = 1'b0;
		ccrM = 8'h00;
		purgeModel();
		fork
			respondLoop();
			monitorLoop();
			watchdog();
		join_none
		repeat (4) @(posedge CLK);
		#0.5;
		RST_N = 1'b1;
		runAccess(1'b1, CCR_WORD, {16'h0, 8'h11, 8'h00}, 4'b0010);
		for (int n = 0; n < RANDOM_TX; n++) begin
			randomAccess();
		end
		lruPhase(1'b0);
		lruPhase(1'b1);
		for (int i = 0; i < 100 && expQ.size() != 0; i++) begin
			@(posedge CLK);
		end
		assert (expQ.size() == 0) else begin
			$display("%0d expected system transfers never appeared.", expQ.size());
			errors++;
		end
		printCounts();
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/cacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheTop import cachePkg::*; #(
	parameter int SET_BITS = 6
) (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic [ADDR_W-1:0]   cpuAddr,
	input  logic [DATA_W-1:0]   cpuWdata,
	input  logic                cpuWrite,
	input  logic [DATA_W/8-1:0] cpuByteEn,
	input  logic                cpuReq,
	output logic [DATA_W-1:0]   cpuRdata,
	output logic                cpuBusy,
	output logic [ADDR_W-1:0]   sysAddr,
	input  logic [DATA_W-1:0]   sysRdata,
	output logic [DATA_W-1:0]   sysWdata,
	output logic [DATA_W/8-1:0] sysByteEn,
	output logic                sysWrite,
	output logic                sysReq,
	input  logic                sysWait,
	output logic                sysLock
);

	logic [WAYS-1:0]     wayHit;
	logic [WAYS-1:0]     victimWay;
	logic [DATA_W-1:0]   readData;
	logic                fillWrite;
	logic [WAYS-1:0]     fillWay;
	logic [ADDR_W-1:0]   fillAddr;
	logic                hitWrite;
	logic [DATA_W/8-1:0] hitByteEn;
	logic                useStrobe;
	logic [WAYS-1:0]     useWay;
	logic [ADDR_W-1:0]   useAddr;
	logic                purgeAll;
	logic                twoWay;

	busController busController_i (
		.CLK(CLK), .RST_N(RST_N),
		.cpuAddr(cpuAddr), .cpuWdata(cpuWdata), .cpuWrite(cpuWrite),
		.cpuByteEn(cpuByteEn), .cpuReq(cpuReq),
		.wayHit(wayHit), .victimWay(victimWay), .readData(readData),
		.sysRdata(sysRdata), .sysWait(sysWait),
		.cpuRdata(cpuRdata), .cpuBusy(cpuBusy),
		.sysAddr(sysAddr), .sysWdata(sysWdata), .sysByteEn(sysByteEn),
		.sysWrite(sysWrite), .sysReq(sysReq), .sysLock(sysLock),
		.fillWrite(fillWrite), .fillWay(fillWay), .fillAddr(fillAddr),
		.hitWrite(hitWrite), .hitByteEn(hitByteEn),
		.useStrobe(useStrobe), .useWay(useWay), .useAddr(useAddr),
		.purgeAll(purgeAll), .twoWay(twoWay)
	);

	tagArray #(.SET_BITS(SET_BITS)) tagArray_i (
		.CLK(CLK), .RST_N(RST_N), .cpuAddr(cpuAddr),
		.fillWrite(fillWrite), .fillWay(fillWay), .fillAddr(fillAddr),
		.purgeAll(purgeAll), .wayHit(wayHit)
	);

	dataArray #(.SET_BITS(SET_BITS)) dataArray_i (
		.CLK(CLK), .cpuAddr(cpuAddr), .cpuWdata(cpuWdata),
		.fillWrite(fillWrite), .fillWay(fillWay), .fillAddr(fillAddr),
		.sysRdata(sysRdata), .hitWrite(hitWrite), .hitByteEn(hitByteEn),
		.wayHit(wayHit), .readData(readData)
	);

	lruState #(.SET_BITS(SET_BITS)) lruState_i (
		.CLK(CLK), .RST_N(RST_N), .cpuAddr(cpuAddr),
		.useStrobe(useStrobe), .useWay(useWay), .useAddr(useAddr),
		.purgeAll(purgeAll), .twoWay(twoWay), .victimWay(victimWay)
	);

endmodule

`default_nettype wire

/* hdl/busController.sv */
`timescale 1ns/1ps
`default_nettype none

module busController import cachePkg::*; (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic [ADDR_W-1:0]   cpuAddr,
	input  logic [DATA_W-1:0]   cpuWdata,
	input  logic                cpuWrite,
	input  logic [DATA_W/8-1:0] cpuByteEn,
	input  logic                cpuReq,
	input  logic [WAYS-1:0]     wayHit,
	input  logic [WAYS-1:0]     victimWay,
	input  logic [DATA_W-1:0]   readData,
	input  logic [DATA_W-1:0]   sysRdata,
	input  logic                sysWait,
	output logic [DATA_W-1:0]   cpuRdata,
	output logic                cpuBusy,
	output logic [ADDR_W-1:0]   sysAddr,
	output logic [DATA_W-1:0]   sysWdata,
	output logic [DATA_W/8-1:0] sysByteEn,
	output logic                sysWrite,
	output logic                sysReq,
	output logic                sysLock,
	output logic                fillWrite,
	output logic [WAYS-1:0]     fillWay,
	output logic [ADDR_W-1:0]   fillAddr,
	output logic                hitWrite,
	output logic [DATA_W/8-1:0] hitByteEn,
	output logic                useStrobe,
	output logic [WAYS-1:0]     useWay,
	output logic [ADDR_W-1:0]   useAddr,
	output logic                purgeAll,
	output logic                twoWay
);

	busState_t         state;
	area_t             area;
	logic [7:0]        ccr;
	logic [DATA_W-1:0] sysCapture;
	logic [1:0]        fillPos;
	logic              ccrSel;
	logic              cacheable;
	logic              hit;
	logic              accept;
	logic              readHit;
	logic              startWrite;
	logic              startFill;
	logic              startRead;

	always_comb begin
		case (cpuAddr[ADDR_W-1:ADDR_W-3])
			3'b000:  area = CACHED;
			3'b001:  area = UNCACHED;
			3'b111:  area = IO;
			default: area = OTHER;
		endcase
	end

	assign ccrSel = (cpuAddr[ADDR_W-1:2] == CCR_ADDR[ADDR_W-1:2]) && cpuByteEn[1];
	assign cacheable = (area == CACHED) && ccr[CCR_CE_BIT];
	assign hit = |wayHit;

	// nothing new is taken while a purge is being carried out.
	assign accept = cpuReq && (state == IDLE) && !purgeAll;

	assign readHit = accept && !cpuWrite && cacheable && hit;
	assign hitWrite = accept && cpuWrite && cacheable && hit;
	assign startWrite = accept && cpuWrite && !ccrSel && (area != OTHER);
	assign startFill = accept && !cpuWrite && cacheable && !hit;
	assign startRead = accept && !cpuWrite && !cacheable && !ccrSel && (area != OTHER);

	assign fillWrite = (state == FILL) && !sysWait;
	assign fillAddr = sysAddr;
	assign hitByteEn = cpuByteEn;
	assign useStrobe = readHit || hitWrite || fillWrite;
	assign useWay = fillWrite ? fillWay : wayHit;
	assign useAddr = fillWrite ? sysAddr : cpuAddr;
	assign purgeAll = ccr[CCR_CP_BIT];
	assign twoWay = ccr[CCR_TW_BIT];

	// writes complete at once, only misses and uncached reads stall in idle.
	always_comb begin
		case (state)
			IDLE:     cpuBusy = cpuReq && (purgeAll || startFill || startRead);
			READDONE: cpuBusy = 1'b0;
			default:  cpuBusy = cpuReq;
		endcase
	end

	always_comb begin
		if (state == READDONE) begin
			cpuRdata = sysCapture;
		end else if (ccrSel) begin
			cpuRdata = {(DATA_W/8){ccr & CCR_RMASK}};
		end else if (area == CACHED) begin
			cpuRdata = readData;
		end else begin
			cpuRdata = '0;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= IDLE;
			sysReq <= 1'b0;
			sysWrite <= 1'b0;
			sysLock <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (startWrite) begin
						state <= WRITE;
						sysReq <= 1'b1;
						sysWrite <= 1'b1;
					end else if (startFill) begin
						state <= FILL;
						sysReq <= 1'b1;
						sysLock <= 1'b1;
					end else if (startRead) begin
						state <= READ;
						sysReq <= 1'b1;
					end
				end
				WRITE: begin
					if (!sysWait) begin
						state <= IDLE;
						sysReq <= 1'b0;
						sysWrite <= 1'b0;
					end
				end
				READ: begin
					if (!sysWait) begin
						state <= READDONE;
						sysReq <= 1'b0;
					end
				end
				FILL: begin
					// the lock is released once only the critical word remains.
					if (!sysWait) begin
						if (sysAddr[3:2] == fillPos - 2'd1) begin
							sysLock <= 1'b0;
						end
						if (sysAddr[3:2] == fillPos) begin
							state <= IDLE;
							sysReq <= 1'b0;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// a fill starts at the word after the critical one and wraps within the line.
	always_ff @(posedge CLK) begin
		if (startFill) begin
			sysAddr <= {cpuAddr[ADDR_W-1:4], cpuAddr[3:2] + 2'd1, 2'b00};
			sysByteEn <= '1;
			fillPos <= cpuAddr[3:2];
			fillWay <= victimWay;
		end else if (startWrite || startRead) begin
			sysAddr <= cpuAddr;
			sysByteEn <= cpuByteEn;
		end else if (fillWrite) begin
			sysAddr[3:2] <= sysAddr[3:2] + 2'd1;
		end
		if (startWrite) begin
			sysWdata <= cpuWdata;
		end
		if (state == READ && !sysWait) begin
			sysCapture <= sysRdata;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ccr <= '0;
		end else if (accept && cpuWrite && ccrSel) begin
			ccr <= cpuWdata[15:8] & CCR_WMASK;
		end else if (purgeAll) begin
			ccr[CCR_CP_BIT] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/lruState.sv */
`timescale 1ns/1ps
`default_nettype none

module lruState import cachePkg::*; #(
	parameter int SET_BITS = 6
) (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic [ADDR_W-1:0] cpuAddr,
	input  logic              useStrobe,
	input  logic [WAYS-1:0]   useWay,
	input  logic [ADDR_W-1:0] useAddr,
	input  logic              purgeAll,
	input  logic              twoWay,
	output logic [WAYS-1:0]   victimWay
);

	localparam int SETS = 1 << SET_BITS;

	// one bit per pair of ways, set when the higher-numbered way is the newer one.
	// bit 5 is ways 0/1, 4 is 0/2, 3 is 0/3, 2 is 1/2, 1 is 1/3 and 0 is 2/3.
	logic [5:0] lru [SETS];

	function automatic logic [5:0] touch(input logic [3:0] way, input logic [5:0] cur);
		logic [5:0] res;

		if (way[0]) begin
			res = {3'b000, cur[2:0]};
		end else if (way[1]) begin
			res = {1'b1, cur[4:3], 2'b00, cur[0]};
		end else if (way[2]) begin
			res = {cur[5], 1'b1, cur[3], 1'b1, cur[1], 1'b0};
		end else if (way[3]) begin
			res = {cur[5:4], 1'b1, cur[2], 2'b11};
		end else begin
			res = cur;
		end
		return res;
	endfunction

	function automatic logic [3:0] oldest(input logic [5:0] cur, input logic tw);
		logic [3:0] res;

		if (tw) begin
			res = cur[0] ? 4'b0100 : 4'b1000;
		end else if (&cur[5:3]) begin
			res = 4'b0001;
		end else if (!cur[5] && cur[2] && cur[1]) begin
			res = 4'b0010;
		end else if (!cur[4] && !cur[2] && cur[0]) begin
			res = 4'b0100;
		end else begin
			res = 4'b1000;
		end
		return res;
	endfunction

	assign victimWay = oldest(lru[cpuAddr[4 +: SET_BITS]], twoWay);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < SETS; s++) begin
				lru[s] <= '0;
			end
		end else if (purgeAll) begin
			for (int s = 0; s < SETS; s++) begin
				lru[s] <= '0;
			end
		end else if (useStrobe) begin
			lru[useAddr[4 +: SET_BITS]] <= touch(useWay, lru[useAddr[4 +: SET_BITS]]);
		end
	end

endmodule

`default_nettype wire

/* hdl/dataArray.sv */
`timescale 1ns/1ps
`default_nettype none

module dataArray import cachePkg::*; #(
	parameter int SET_BITS = 6
) (
	input  logic                CLK,
	input  logic [ADDR_W-1:0]   cpuAddr,
	input  logic [DATA_W-1:0]   cpuWdata,
	input  logic                fillWrite,
	input  logic [WAYS-1:0]     fillWay,
	input  logic [ADDR_W-1:0]   fillAddr,
	input  logic [DATA_W-1:0]   sysRdata,
	input  logic                hitWrite,
	input  logic [DATA_W/8-1:0] hitByteEn,
	input  logic [WAYS-1:0]     wayHit,
	output logic [DATA_W-1:0]   readData
);

	localparam int LANES = DATA_W / 8;
	localparam int IDX_W = SET_BITS + $clog2(LINE_WORDS);
	localparam int DEPTH = 1 << IDX_W;

	logic [7:0]       mem [WAYS][LANES][DEPTH];
	logic [IDX_W-1:0] rdIdx;
	logic [IDX_W-1:0] wrIdx;

	assign rdIdx = cpuAddr[2 +: IDX_W];
	assign wrIdx = fillAddr[2 +: IDX_W];

	// a fill writes whole words, a write hit only its enabled lanes.
	always_ff @(posedge CLK) begin
		for (int w = 0; w < WAYS; w++) begin
			for (int b = 0; b < LANES; b++) begin
				if (fillWrite && fillWay[w]) begin
					mem[w][b][wrIdx] <= sysRdata[8*b +: 8];
				end else if (hitWrite && wayHit[w] && hitByteEn[b]) begin
					mem[w][b][rdIdx] <= cpuWdata[8*b +: 8];
				end
			end
		end
	end

	always_comb begin
		readData = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (wayHit[w]) begin
				for (int b = 0; b < LANES; b++) begin
					readData[8*b +: 8] = mem[w][b][rdIdx];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/tagArray.sv */
`timescale 1ns/1ps
`default_nettype none

module tagArray import cachePkg::*; #(
	parameter int SET_BITS = 6
) (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic [ADDR_W-1:0] cpuAddr,
	input  logic              fillWrite,
	input  logic [WAYS-1:0]   fillWay,
	input  logic [ADDR_W-1:0] fillAddr,
	input  logic              purgeAll,
	output logic [WAYS-1:0]   wayHit
);

	localparam int SETS = 1 << SET_BITS;
	localparam int TAG_LO = 4 + SET_BITS;
	localparam int TAG_W = 29 - TAG_LO;

	logic [TAG_W-1:0]    tagMem [WAYS][SETS];
	logic [SETS-1:0]     valid [WAYS];
	logic [SET_BITS-1:0] rdSet;
	logic [SET_BITS-1:0] wrSet;

	assign rdSet = cpuAddr[4 +: SET_BITS];
	assign wrSet = fillAddr[4 +: SET_BITS];

	// all ways are compared in parallel, at most one can match.
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			wayHit[w] = valid[w][rdSet] && (tagMem[w][rdSet] == cpuAddr[28:TAG_LO]);
		end
	end

	always_ff @(posedge CLK) begin
		for (int w = 0; w < WAYS; w++) begin
			if (fillWrite && fillWay[w]) begin
				tagMem[w][wrSet] <= fillAddr[28:TAG_LO];
			end
		end
	end

	// the tag becomes valid with the first word of a fill.
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int w = 0; w < WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (purgeAll) begin
			for (int w = 0; w < WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (fillWrite) begin
			for (int w = 0; w < WAYS; w++) begin
				if (fillWay[w]) begin
					valid[w][wrSet] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/cachePkg.sv */
`default_nettype none

package cachePkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int WAYS = 4;
	localparam int LINE_WORDS = 4;

	// the control register is a single byte on lane 1 of this word.
	localparam logic [ADDR_W-1:0] CCR_ADDR = 32'hFFFFFE92;

	localparam int CCR_CE_BIT = 0;
	localparam int CCR_TW_BIT = 3;
	localparam int CCR_CP_BIT = 4;

	localparam logic [7:0] CCR_WMASK = (8'h01 << CCR_CE_BIT) |
	                                   (8'h01 << CCR_TW_BIT) |
	                                   (8'h01 << CCR_CP_BIT);

	// purge reads back as zero.
	localparam logic [7:0] CCR_RMASK = (8'h01 << CCR_CE_BIT) |
	                                   (8'h01 << CCR_TW_BIT);

	// address areas, taken from the top three address bits.
	typedef enum logic [2:0] {
		CACHED   = 3'b000,
		UNCACHED = 3'b001,
		IO       = 3'b111,
		OTHER    = 3'b010
	} area_t;

	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		READ,
		FILL,
		READDONE
	} busState_t;

endpackage

`default_nettype wire
